// File: verilog/fetch_pkg.sv
package fetch_pkg;

    // fetch address after reset
    localparam logic [31:0] PC_RESET = 32'h1c00_0000;
    localparam logic [31:0] INST_NOP = 32'h0340_0000;  // andi r0, r0, 0

    // ibar keeps its hint in the low 15 bits, only the upper 17 are fixed
    localparam logic [31:0] IBAR_OPCODE = 32'h3872_8000;
    localparam logic [31:0] IBAR_MASK   = 32'hffff_8000;

    localparam int unsigned FBUF_DEPTH = 8;
    localparam int unsigned FBUF_PTR_W = 3;
    // occupancy count needs one bit more than the pointers
    localparam logic [FBUF_PTR_W:0] FBUF_CNT_MAX = (FBUF_PTR_W + 1)'(FBUF_DEPTH);

    // one instruction pair as returned by the icache
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic        excp_flag;
        logic [6:0]  ecode;
        logic [31:0] badv;
    } fetch_resp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [1:0]  slot_valid;  // bit 0 is inst0
        logic        excp_flag;
        logic [6:0]  ecode;
        logic [31:0] badv;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        IDLE            = 2'b00,
        WAIT_EX_IBAR    = 2'b01,
        WAIT_CACHE_IDLE = 2'b11,
        WAIT_FETCH      = 2'b10
    } barrier_state_t;

    // empty stage contents, a nop pair at the reset pc
    localparam fetch_entry_t ENTRY_BUBBLE = '{
        pc:         PC_RESET,
        inst0:      INST_NOP,
        inst1:      INST_NOP,
        slot_valid: 2'b00,
        excp_flag:  1'b0,
        ecode:      7'd0,
        badv:       32'd0
    };

endpackage

// File: verilog/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic        buf_allowin,
    input  logic        fetch_hold,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        resp_valid,
    output logic        fetch_req,
    output logic [31:0] fetch_pc,
    output logic        resp_take
);
    import fetch_pkg::*;

    logic outstanding;  // request sent, response not back yet
    logic stale;        // the in-flight response belongs to a flushed stream
    logic issue;

    // one request at a time, and only with a buffer slot to land in
    assign issue = !outstanding && buf_allowin && !fetch_hold && !redirect_valid && !flush;

    assign resp_take = resp_valid && !stale && !flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_req   <= 1'b0;
            fetch_pc    <= PC_RESET;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end else begin
            fetch_req <= issue;

            if (issue) begin
                outstanding <= 1'b1;
            end else if (resp_valid) begin
                outstanding <= 1'b0;
            end

            // a response arriving in the flush cycle is simply dropped
            if (flush) begin
                stale <= outstanding && !resp_valid;
            end else if (resp_valid) begin
                stale <= 1'b0;
            end

            if (flush) begin
                fetch_pc <= flush_pc;
            end else if (redirect_valid) begin
                fetch_pc <= redirect_pc;  // refetch after ibar
            end else if (fetch_req) begin
                fetch_pc <= fetch_pc + 32'd8;
            end
        end
    end

    // the cache answers only what was asked
    a_resp_has_req: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> outstanding)
        else $error("resp_valid at %0t with no fetch request outstanding", $time);

endmodule

// File: verilog/fetch_predecode.sv
`timescale 1ns/1ps

module fetch_predecode (
    input  fetch_pkg::fetch_resp_t resp,
    output logic                   ibar_hit,
    output logic                   ibar_slot1,
    output logic [1:0]             slot_valid
);
    import fetch_pkg::*;

    logic hit0;
    logic hit1;

    // hint bits are ignored
    function automatic logic is_ibar(input logic [31:0] inst);
        logic [31:0] fixed_bits;
        fixed_bits = inst & IBAR_MASK;
        return fixed_bits == IBAR_OPCODE;
    endfunction

    // a faulting fetch carries no usable instructions
    assign hit0 = !resp.excp_flag && is_ibar(resp.inst0);
    assign hit1 = !resp.excp_flag && is_ibar(resp.inst1);

    assign ibar_hit   = hit0 || hit1;
    assign ibar_slot1 = hit1 && !hit0;  // slot 0 wins when both match

    // after an ibar in slot 0 the second word is refetched later
    assign slot_valid = hit0 ? 2'b01 : 2'b11;

endmodule

// File: verilog/if1_fifo_stage.sv
`timescale 1ns/1ps

module if1_fifo_stage (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    input  logic                    resp_take,
    input  fetch_pkg::fetch_resp_t  resp,
    input  logic                    ibar_hit,
    input  logic                    ibar_slot1,
    input  logic [1:0]              slot_valid,
    input  logic                    ibar_commit,
    input  logic                    icache_idle,
    input  logic                    dcache_idle,
    input  logic                    buf_allowin,
    output logic                    stage_valid,
    output fetch_pkg::fetch_entry_t stage_entry,
    output logic                    fetch_hold,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc
);
    import fetch_pkg::*;

    barrier_state_t state;
    barrier_state_t state_nxt;
    logic [31:0]    pc_after_ibar;
    logic           cache_idle;
    logic           pc_fetch_ok;
    logic           ibar_take;
    fetch_entry_t   entry_in;

    assign cache_idle  = icache_idle && dcache_idle;
    assign pc_fetch_ok = resp.pc == pc_after_ibar;

    // the refetched pair may itself hold another ibar
    assign ibar_take = resp_take && ibar_hit &&
                       (state == IDLE || (state == WAIT_FETCH && pc_fetch_ok));

    assign entry_in = '{
        pc:         resp.pc,
        inst0:      resp.inst0,
        inst1:      resp.inst1,
        slot_valid: slot_valid,
        excp_flag:  resp.excp_flag,
        ecode:      resp.ecode,
        badv:       resp.badv
    };

    // IDLE -> WAIT_EX_IBAR -> WAIT_CACHE_IDLE -> WAIT_FETCH -> IDLE
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ibar_take) state_nxt = WAIT_EX_IBAR;
            end
            WAIT_EX_IBAR: begin
                if (ibar_commit) state_nxt = WAIT_CACHE_IDLE;  // execute reached it
            end
            WAIT_CACHE_IDLE: begin
                if (cache_idle) state_nxt = WAIT_FETCH;
            end
            WAIT_FETCH: begin
                if (resp_take && pc_fetch_ok) begin
                    state_nxt = ibar_take ? WAIT_EX_IBAR : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign fetch_hold  = (state == WAIT_EX_IBAR) || (state == WAIT_CACHE_IDLE);
    assign redirect_pc = pc_after_ibar;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state          <= IDLE;
            pc_after_ibar  <= PC_RESET;
            redirect_valid <= 1'b0;
        end else if (flush) begin
            state          <= IDLE;
            pc_after_ibar  <= PC_RESET;
            redirect_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            // single pulse on entry to WAIT_FETCH
            redirect_valid <= (state == WAIT_CACHE_IDLE) && cache_idle;
            if (ibar_take) begin
                pc_after_ibar <= resp.pc + (ibar_slot1 ? 32'd8 : 32'd4);
            end
        end
    end

    // stage register, pushed into the buffer the cycle after capture
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_valid <= 1'b0;
            stage_entry <= ENTRY_BUBBLE;
        end else if (flush) begin
            stage_valid <= 1'b0;
            stage_entry <= ENTRY_BUBBLE;
        end else begin
            stage_valid <= resp_take;
            if (resp_take) begin
                stage_entry <= entry_in;
            end else if (buf_allowin) begin
                stage_entry <= ENTRY_BUBBLE;  // drained, back to a nop pair
            end
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {IDLE, WAIT_EX_IBAR, WAIT_CACHE_IDLE, WAIT_FETCH})
        else $error("if1 barrier state left the legal set: %s", state.name());

    // pc generator must not have a request in flight while held
    a_hold_no_resp: assert property (@(posedge clk) disable iff (!rstn)
        fetch_hold |-> !resp_take)
        else $error("response taken during barrier state %s", state.name());

endmodule

// File: verilog/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    input  logic                    stage_valid,
    input  fetch_pkg::fetch_entry_t stage_entry,
    input  logic                    dec_pop,
    output logic                    buf_allowin,
    output logic                    dec_valid,
    output fetch_pkg::fetch_entry_t dec_entry
);
    import fetch_pkg::*;

    fetch_entry_t          mem [FBUF_DEPTH];
    logic [FBUF_PTR_W-1:0] wr_ptr;
    logic [FBUF_PTR_W-1:0] rd_ptr;
    logic [FBUF_PTR_W:0]   count;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = count == FBUF_CNT_MAX;

    // flush wins, nothing moves in that cycle
    assign push = stage_valid && !flush;
    assign pop  = dec_pop && dec_valid && !flush;

    assign dec_valid = count != '0;
    assign dec_entry = mem[rd_ptr];  // head of queue

    // the entry sitting in the stage already owns a slot
    assign buf_allowin = stage_valid ? (count < FBUF_CNT_MAX - 1'b1) : !full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= stage_entry;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // relies on the pc generator reserving a slot per request
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full)
        else $error("fetch buffer push while full at %0t", $time);

endmodule

// File: verilog/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                    clk,
    input  logic                    rstn,
    output logic                    fetch_req,
    output logic [31:0]             fetch_pc,
    input  logic                    resp_valid,
    input  fetch_pkg::fetch_resp_t  resp,
    input  logic                    flush,
    input  logic [31:0]             flush_pc,
    input  logic                    ibar_commit,
    input  logic                    icache_idle,
    input  logic                    dcache_idle,
    input  logic                    dec_pop,
    output logic                    dec_valid,
    output fetch_pkg::fetch_entry_t dec_entry
);
    import fetch_pkg::*;

    logic         resp_take;
    logic         ibar_hit;
    logic         ibar_slot1;
    logic [1:0]   slot_valid;
    logic         stage_valid;
    fetch_entry_t stage_entry;
    logic         buf_allowin;
    logic         fetch_hold;
    logic         redirect_valid;
    logic [31:0]  redirect_pc;

    fetch_pc_gen i_pc_gen (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .buf_allowin    (buf_allowin),
        .fetch_hold     (fetch_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .resp_valid     (resp_valid),
        .fetch_req      (fetch_req),
        .fetch_pc       (fetch_pc),
        .resp_take      (resp_take)
    );

    // looks at the raw response, the stage decides whether to take it
    fetch_predecode i_predecode (
        .resp       (resp),
        .ibar_hit   (ibar_hit),
        .ibar_slot1 (ibar_slot1),
        .slot_valid (slot_valid)
    );

    if1_fifo_stage i_if1_stage (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .resp_take      (resp_take),
        .resp           (resp),
        .ibar_hit       (ibar_hit),
        .ibar_slot1     (ibar_slot1),
        .slot_valid     (slot_valid),
        .ibar_commit    (ibar_commit),
        .icache_idle    (icache_idle),
        .dcache_idle    (dcache_idle),
        .buf_allowin    (buf_allowin),
        .stage_valid    (stage_valid),
        .stage_entry    (stage_entry),
        .fetch_hold     (fetch_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    fetch_buffer i_fetch_buf (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .stage_valid (stage_valid),
        .stage_entry (stage_entry),
        .dec_pop     (dec_pop),
        .buf_allowin (buf_allowin),
        .dec_valid   (dec_valid),
        .dec_entry   (dec_entry)
    );

endmodule

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam int          NUM_ENTRIES = 400;
    localparam int          CYCLE_LIMIT = NUM_ENTRIES * 60;  // barrier, stalls, margin
    localparam logic [31:0] EXCP_BASE   = 32'h1c00_0800;
    localparam logic [6:0]  EXCP_ECODE  = 7'h08;

    logic         clk = 1'b0;
    logic         rstn = 1'b0;
    logic         fetch_req;
    logic [31:0]  fetch_pc;
    logic         resp_valid = 1'b0;
    fetch_resp_t  resp = '0;
    logic         flush = 1'b0;
    logic [31:0]  flush_pc = '0;
    logic         ibar_commit = 1'b0;
    logic         icache_idle = 1'b0;
    logic         dcache_idle = 1'b0;
    logic         dec_pop = 1'b0;
    logic         dec_valid;
    fetch_entry_t dec_entry;

    integer      seed = 65098;
    int          cycle_cnt = 0;
    int          checked = 0;
    int          owed = 0;          // requested but not yet popped
    logic [31:0] model_pc = PC_RESET;
    logic        cache_busy = 1'b0;
    int          cache_wait = 0;
    logic [31:0] cache_pc = '0;
    int          commit_wait = 0;
    int          stall_left = 0;
    logic        need_release = 1'b0;  // next pop is a refetch after ibar
    logic        commit_seen = 1'b0;
    logic        released = 1'b0;
    int          n_ibar = 0;
    int          n_excp = 0;
    int          n_flush = 0;

    fetch_frontend i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .ibar_commit (ibar_commit),
        .icache_idle (icache_idle),
        .dcache_idle (dcache_idle),
        .dec_pop     (dec_pop),
        .dec_valid   (dec_valid),
        .dec_entry   (dec_entry)
    );

    always #4 clk = ~clk;

    function automatic logic ibar_word(input logic [31:0] w);
        return (w & IBAR_MASK) == IBAR_OPCODE;
    endfunction

    function automatic logic in_excp_range(input logic [31:0] pc);
        return pc >= EXCP_BASE && pc < EXCP_BASE + 32'h100;
    endfunction

    // instruction memory as a hash of the full word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        if (h[31:24] % 8'd12 == 8'd0) begin
            return IBAR_OPCODE | {17'd0, h[14:0]};  // roughly one word in twelve
        end
        return ibar_word(h) ? h ^ 32'h8000_0000 : h;  // no accidental ibar
    endfunction

    function automatic fetch_resp_t cache_response(input logic [31:0] pc);
        fetch_resp_t r;
        r.pc        = pc;
        r.inst0     = mem_word(pc);
        r.inst1     = mem_word(pc + 32'd4);
        r.excp_flag = in_excp_range(pc);
        r.ecode     = r.excp_flag ? EXCP_ECODE : 7'd0;
        r.badv      = r.excp_flag ? pc : 32'd0;
        return r;
    endfunction

    // next entry of the expected stream and where the stream continues
    task automatic expected_entry(output fetch_entry_t e, output logic [31:0] next_pc);
        e            = '0;
        e.pc         = model_pc;
        e.inst0      = mem_word(model_pc);
        e.inst1      = mem_word(model_pc + 32'd4);
        e.slot_valid = 2'b11;
        next_pc      = model_pc + 32'd8;
        if (in_excp_range(model_pc)) begin
            e.excp_flag = 1'b1;
            e.ecode     = EXCP_ECODE;
            e.badv      = model_pc;
        end else if (ibar_word(e.inst0)) begin
            e.slot_valid = 2'b01;
            next_pc      = model_pc + 32'd4;  // resume right after the ibar
        end
    endtask

    task automatic check_value(input string what, input logic [137:0] got,
                               input logic [137:0] want);
        if (got !== want) begin
            $display("MISMATCH time %0t: %s, got %h expected %h", $time, what, got, want);
            $display("Test failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // called at the falling edge, all signals of the cycle are settled
    task automatic sample_cycle();
        fetch_entry_t want;
        logic [31:0]  next_pc;
        logic         pop;
        pop = dec_valid && dec_pop && !flush;
        if (fetch_req) begin
            check_value("second request while one is outstanding", cache_busy, 1'b0);
            // the stream is linear between barriers, unpopped requests sit ahead
            if (!flush) begin
                check_value("fetch address", fetch_pc, model_pc + 32'(owed * 8));
            end
            cache_busy = 1'b1;
            cache_wait = 1 + {$random(seed)} % 4;
            cache_pc   = fetch_pc;
        end
        // idle only counts in a cycle after the commit
        if (need_release && commit_seen && icache_idle && dcache_idle) released = 1'b1;
        if (need_release && ibar_commit) commit_seen = 1'b1;
        if (flush) begin
            model_pc     = flush_pc;
            owed         = 0;
            need_release = 1'b0;
            commit_wait  = 0;
            n_flush++;
        end else begin
            owed = owed + int'(fetch_req) - int'(pop);
            check_value("request issued with the fetch buffer full", owed <= FBUF_DEPTH, 1'b1);
        end
        if (pop) begin
            expected_entry(want, next_pc);
            check_value("popped entry", dec_entry, want);
            if (need_release) begin
                check_value("refetch before ibar commit and idle caches", released, 1'b1);
            end
            need_release = !want.excp_flag && (ibar_word(want.inst0) || ibar_word(want.inst1));
            commit_seen  = 1'b0;
            released     = 1'b0;
            if (need_release) begin
                commit_wait = 2 + {$random(seed)} % 9;  // execute reaches it later
                n_ibar++;
            end
            n_excp += int'(want.excp_flag);
            model_pc = next_pc;
            checked++;
        end
    endtask

    // called 1 ns after the rising edge
    task automatic drive_cycle();
        resp_valid = 1'b0;
        resp       = '0;
        if (cache_busy) begin
            if (cache_wait == 1) begin
                resp_valid = 1'b1;
                resp       = cache_response(cache_pc);
                cache_busy = 1'b0;
            end
            cache_wait--;
        end
        ibar_commit = 1'b0;
        if (commit_wait != 0) begin
            ibar_commit = commit_wait == 1;
            commit_wait--;
        end
        flush = {$random(seed)} % 80 == 0;
        if (flush) begin
            // some flushes land just ahead of the faulting range
            flush_pc = ({$random(seed)} % 4 == 0) ? EXCP_BASE - 32'h40
                                                  : PC_RESET + ({$random(seed)} % 1024) * 32'd8;
        end
        if (stall_left != 0) begin
            dec_pop = 1'b0;
            stall_left--;
        end else if ({$random(seed)} % 200 == 0) begin
            dec_pop    = 1'b0;
            stall_left = 48;  // long enough to fill the buffer
        end else begin
            dec_pop = {$random(seed)} % 4 != 0;
        end
        icache_idle = {$random(seed)} % 3 != 0;
        dcache_idle = {$random(seed)} % 3 != 0;
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: only %0d of %0d entries checked after %0d cycles",
                     checked, NUM_ENTRIES, cycle_cnt);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (checked < NUM_ENTRIES) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            #1;
            drive_cycle();
        end
        $display("checked %0d entries, %0d ibar, %0d exception, %0d flushes",
                 checked, n_ibar, n_excp, n_flush);
        $display("Test passed");
        $finish;
    end

endmodule

// File: fetch_frontend.f
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_predecode.sv
verilog/if1_fifo_stage.sv
verilog/fetch_buffer.sv
verilog/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it
# the exit status is nonzero when the simulation reports a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_frontend \
    -f fetch_frontend.f \
    -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend \
    || { echo "fetch_frontend build or simulation failed"; exit 1; }
